/* include/eth_tx_macros.svh */
`ifndef ETH_TX_MACROS_SVH
`define ETH_TX_MACROS_SVH

// APB address width
`define ETH_TX_ADDR_WIDTH 16

// Frame byte count, so at most 2047 bytes per frame
`define ETH_TX_LEN_WIDTH 11

// FIFO depths, powers of two
`define ETH_TX_DATA_DEPTH 2048
`define ETH_TX_HDR_DEPTH 32

// Register map
// Bit 0 of the status register is the link state
`define ETH_TX_REG_STAT 16'h0000
`define ETH_TX_REG_COMMIT 16'h0004
`define ETH_TX_REG_LENGTH 16'h0008
// Every address from here upward lands in the frame buffer
`define ETH_TX_REG_TX_BUF 16'h0010

`endif

/* src.f */
+incdir+include
verilog/eth_tx_pkg.sv
verilog/apb_tx_regs.sv
verilog/sync_fifo.sv
verilog/tx_frame_sender.sv
verilog/eth_tx_buffer.sv
verification/tb_clock_gen.sv
verification/eth_tx_buffer_tb.sv

/* verification/eth_tx_buffer_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_macros.svh"

module eth_tx_buffer_tb;

	localparam int apb_timeout = 5000;
	localparam int drain_timeout = 20000;

	logic apb;
	logic rst;
	eth_tx_pkg::apb_req_t req;
	eth_tx_pkg::apb_rsp_t rsp;
	eth_tx_pkg::tx_bus_t tx;
	logic link_up;
	logic tx_ready;

	// Xorshift state
	logic [31:0] rng_state = 32'd43;
	int mismatch_count = 0;
	int other_errors = 0;

	// Expected frames, bytes back to back plus one length per frame
	logic [7:0] exp_bytes[$];
	int exp_lens[$];

	// Monitor state
	logic [7:0] got[$];
	logic in_frame = 1'b0;
	int start_count = 0;
	int frame_num = 0;

	tb_clock_gen i_clock_gen (
		.apb(apb),
		.rst(rst)
	);

	eth_tx_buffer i_eth_tx_buffer (
		.apb(apb),
		.rst(rst),
		.req(req),
		.link_up(link_up),
		.tx_ready(tx_ready),
		.rsp(rsp),
		.tx(tx)
	);

	////////////////////
	// Helpers

	function automatic logic [31:0] next_rand();
		logic [31:0] s;
		s = rng_state;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		rng_state = s;
		return s;
	endfunction

	// Frame length 1 to 64
	function automatic int rand_len();
		return int'(next_rand() % 64) + 1;
	endfunction

	// Closing line with the counts, then the verdict
	task automatic end_run();
		$display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	endtask

	// One APB transfer, setup then access until pready
	task automatic apb_transfer(input logic write, input logic [15:0] addr,
			input logic [31:0] wdata, input logic [3:0] strb,
			output logic [31:0] rdata, output logic slverr, output int stalls);
		int waited;
		logic done;
		waited = 0;
		done = 1'b0;
		rdata = '0;
		slverr = 1'b0;
		stalls = 0;
		@(negedge apb);
		req.psel = 1'b1;
		req.penable = 1'b0;
		req.pwrite = write;
		req.paddr = addr;
		req.pwdata = wdata;
		req.pstrb = strb;
		@(negedge apb);
		req.penable = 1'b1;
		while (!done && waited < apb_timeout) begin
			// pready only moves on the rising edge
			#1;
			if (rsp.pready) begin
				done = 1'b1;
				rdata = rsp.prdata;
				slverr = rsp.pslverr;
			end else begin
				@(negedge apb);
				waited++;
			end
		end
		if (!done) begin
			$display("Timeout: pready never came for the access to 0x%h", addr);
			other_errors++;
			end_run();
		end else begin
			stalls = waited;
			@(negedge apb);
			req = '0;
		end
	endtask

	task automatic check_access(input logic write, input logic [15:0] addr,
			input logic exp_err);
		logic [31:0] rdata;
		logic slverr;
		int stalls;
		apb_transfer(write, addr, 32'd0, 4'hf, rdata, slverr, stalls);
		if (slverr !== exp_err) begin
			mismatch_count++;
			$display("MISMATCH at %0t: %s of 0x%h gave pslverr %b, expected %b",
				$time, write ? "write" : "read", addr, slverr, exp_err);
		end
	endtask

	task automatic check_status(input logic link);
		logic [31:0] rdata;
		logic slverr;
		int stalls;
		apb_transfer(1'b0, `ETH_TX_REG_STAT, 32'd0, 4'hf, rdata, slverr, stalls);
		if (rdata !== {31'd0, link} || slverr !== 1'b0) begin
			mismatch_count++;
			$display("MISMATCH at %0t: status read 0x%h pslverr %b, link is %b",
				$time, rdata, slverr, link);
		end
	endtask

	// Writes length, random strobed words, junk past the end, then commit
	task automatic send_frame(input int len);
		logic [31:0] word;
		logic [31:0] rdata;
		logic slverr;
		int stalls;
		int nbytes;
		int written;
		int extra;
		int i;
		logic [7:0] frame[$];
		apb_transfer(1'b1, `ETH_TX_REG_LENGTH, 32'(len), 4'hf, rdata, slverr, stalls);
		written = 0;
		while (written < len) begin
			nbytes = int'(next_rand() % 4) + 1;
			word = next_rand();
			apb_transfer(1'b1, `ETH_TX_REG_TX_BUF + 16'(4 * (next_rand() % 64)), word,
				4'b1111 >> (4 - nbytes), rdata, slverr, stalls);
			for (i = 0; i < nbytes; i++) begin
				// Bytes of the last word past the length are dropped
				if (written < len) begin
					frame.push_back(word[8*i +: 8]);
					written++;
				end
			end
		end
		extra = int'(next_rand() % 3);
		for (i = 0; i < extra; i++) begin
			nbytes = int'(next_rand() % 4) + 1;
			apb_transfer(1'b1, `ETH_TX_REG_TX_BUF, next_rand(), 4'b1111 >> (4 - nbytes),
				rdata, slverr, stalls);
		end
		foreach (frame[i])
			exp_bytes.push_back(frame[i]);
		exp_lens.push_back(len);
		apb_transfer(1'b1, `ETH_TX_REG_COMMIT, 32'd0, 4'hf, rdata, slverr, stalls);
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		while ((exp_lens.size() != 0 || in_frame) && waited < drain_timeout) begin
			@(negedge apb);
			waited++;
		end
		if (exp_lens.size() != 0 || in_frame) begin
			$display("Timeout: %0d committed frames were never sent", exp_lens.size());
			other_errors++;
			end_run();
		end
	endtask

	////////////////////
	// Monitor

	// Finished frame against the head of the model
	task automatic compare_frame();
		int len;
		int i;
		logic [7:0] want;
		frame_num++;
		if (exp_lens.size() == 0) begin
			mismatch_count++;
			$display("MISMATCH at %0t: frame %0d of %0d bytes was not expected",
				$time, frame_num, got.size());
		end else begin
			len = exp_lens.pop_front();
			if (got.size() != len) begin
				mismatch_count++;
				$display("MISMATCH at %0t: frame %0d has %0d bytes, expected %0d",
					$time, frame_num, got.size(), len);
			end
			for (i = 0; i < len; i++) begin
				want = exp_bytes.pop_front();
				if (i < got.size() && got[i] !== want) begin
					mismatch_count++;
					$display("MISMATCH at %0t: frame %0d byte %0d is 0x%h, expected 0x%h",
						$time, frame_num, i, got[i], want);
				end
			end
		end
	endtask

	// Bus outputs are registered, so the falling edge sees them settled
	always @(negedge apb) begin
		if (rst) begin
			in_frame = 1'b0;
			got.delete();
		end else begin
			if (tx.start) begin
				start_count++;
				if (!tx.data_valid || in_frame) begin
					mismatch_count++;
					$display("MISMATCH at %0t: start without a first byte or inside a frame",
						$time);
				end
				got.delete();
				in_frame = 1'b1;
			end
			if (tx.data_valid) begin
				if (!in_frame) begin
					mismatch_count++;
					$display("MISMATCH at %0t: data_valid with no start", $time);
				end
				got.push_back(tx.data);
				in_frame = 1'b1;
			end else if (in_frame) begin
				// A gap ends the frame
				compare_frame();
				in_frame = 1'b0;
			end
		end
	end

	////////////////////
	// Stimulus

	initial begin
		int waited;
		int i;
		int stalls;
		int starts_before;
		logic [31:0] rdata;
		logic slverr;
		req = '0;
		link_up = 1'b1;
		tx_ready = 1'b1;
		waited = 0;
		while (rst !== 1'b0 && waited < 100) begin
			@(negedge apb);
			waited++;
		end
		if (rst !== 1'b0) begin
			$display("Reset was never released");
			other_errors++;
			end_run();
		end
		if (rsp.pready !== 1'b0 || tx.start !== 1'b0 || tx.data_valid !== 1'b0) begin
			mismatch_count++;
			$display("MISMATCH at %0t: outputs not idle after reset", $time);
		end

		// Register map and pslverr
		check_status(1'b1);
		link_up = 1'b0;
		check_status(1'b0);
		link_up = 1'b1;
		check_access(1'b1, `ETH_TX_REG_STAT, 1'b1);
		check_access(1'b0, `ETH_TX_REG_COMMIT, 1'b1);
		check_access(1'b0, `ETH_TX_REG_LENGTH, 1'b1);
		check_access(1'b0, `ETH_TX_REG_TX_BUF, 1'b1);
		check_access(1'b1, `ETH_TX_REG_LENGTH, 1'b0);
		check_access(1'b1, `ETH_TX_REG_COMMIT, 1'b0);

		// Random frames with random MAC readiness
		for (i = 0; i < 20; i++) begin
			tx_ready = (next_rand() % 2) != 0;
			send_frame(rand_len());
		end
		tx_ready = 1'b1;
		wait_drained();

		// MAC not ready, fill the length FIFO to its stall point
		tx_ready = 1'b0;
		starts_before = start_count;
		for (i = 0; i < 31; i++)
			send_frame(rand_len());
		repeat (50) @(negedge apb);
		if (start_count != starts_before) begin
			mismatch_count++;
			$display("MISMATCH at %0t: start seen while tx_ready was low", $time);
		end
		fork
			begin
				repeat (20) @(negedge apb);
				tx_ready = 1'b1;
			end
			begin
				// Held off until the sender pops a length
				apb_transfer(1'b1, `ETH_TX_REG_LENGTH, 32'd0, 4'hf, rdata, slverr, stalls);
				send_frame(rand_len());
			end
		join
		if (stalls < 10) begin
			mismatch_count++;
			$display("MISMATCH at %0t: APB stalled %0d cycles with a full length FIFO",
				$time, stalls);
		end
		wait_drained();

		// Link loss discards committed frames
		tx_ready = 1'b0;
		for (i = 0; i < 3; i++)
			send_frame(rand_len());
		link_up = 1'b0;
		repeat (5) @(negedge apb);
		exp_lens.delete();
		exp_bytes.delete();
		link_up = 1'b1;
		starts_before = start_count;
		// Empty commit leaves no frame
		check_access(1'b1, `ETH_TX_REG_LENGTH, 1'b0);
		check_access(1'b1, `ETH_TX_REG_COMMIT, 1'b0);
		tx_ready = 1'b1;
		for (i = 0; i < 3; i++)
			send_frame(rand_len());
		wait_drained();
		repeat (20) @(negedge apb);
		if (start_count - starts_before != 3) begin
			mismatch_count++;
			$display("MISMATCH at %0t: %0d frames after link loss, expected 3",
				$time, start_count - starts_before);
		end
		end_run();
	end

endmodule

`default_nettype wire

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic apb,
	output logic rst
);

	// 4 ns period
	initial begin
		apb = 1'b0;
		forever #2 apb = ~apb;
	end

	// Reset held over 8 rising edges, released on a falling edge
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge apb);
		@(negedge apb);
		rst = 1'b0;
	end

endmodule

`default_nettype wire

/* verilog/apb_tx_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_macros.svh"

module apb_tx_regs (
	input wire apb,
	input wire rst,
	input wire eth_tx_pkg::apb_req_t req,
	input wire link_up,
	input wire [$clog2(`ETH_TX_DATA_DEPTH + 1)-1:0] data_free,
	input wire [$clog2(`ETH_TX_HDR_DEPTH + 1)-1:0] len_free,
	output eth_tx_pkg::apb_rsp_t rsp,
	output logic byte_wr,
	output logic [7:0] byte_data,
	output logic len_wr,
	output eth_tx_pkg::frame_len_t len_data
);

	// Completed writes by target
	logic buf_wr;
	logic len_set;
	logic commit;

	// Bytes of the last buffer word still to push
	logic [23:0] pend_bytes;
	logic [1:0] pend_cnt;
	logic [1:0] extra;

	// Bytes pushed so far and the length announced by software
	eth_tx_pkg::frame_len_t byte_cnt;
	eth_tx_pkg::frame_len_t exp_len;
	logic room;

	// FIFO almost full, registered so pready stays short
	logic data_af;
	logic len_af;

	////////////////////
	// APB completer

	always_comb begin
		rsp = '0;
		// Stall while serializing or while either FIFO is nearly full
		rsp.pready = req.psel && req.penable && (pend_cnt == 2'd0) && !data_af && !len_af;
		if (rsp.pready) begin
			if (req.pwrite) begin
				// Status is read only
				if (req.paddr == `ETH_TX_REG_STAT)
					rsp.pslverr = 1'b1;
			end else if (req.paddr == `ETH_TX_REG_STAT) begin
				rsp.prdata = {31'd0, link_up};
			end else begin
				// Buffer and control registers are write only
				rsp.pslverr = 1'b1;
			end
		end
	end

	assign buf_wr = rsp.pready && req.pwrite && (req.paddr >= `ETH_TX_REG_TX_BUF);
	assign len_set = rsp.pready && req.pwrite && (req.paddr == `ETH_TX_REG_LENGTH);
	assign commit = rsp.pready && req.pwrite && (req.paddr == `ETH_TX_REG_COMMIT);
	assign room = byte_cnt < exp_len;

	// Strobed bytes above byte 0
	always_comb begin
		if (req.pstrb[3])
			extra = 2'd3;
		else if (req.pstrb[2])
			extra = 2'd2;
		else if (req.pstrb[1])
			extra = 2'd1;
		else
			extra = 2'd0;
	end

	////////////////////
	// Serializer and commit

	always_ff @(posedge apb) begin
		if (rst) begin
			byte_wr <= 1'b0;
			len_wr <= 1'b0;
			pend_cnt <= 2'd0;
			byte_cnt <= '0;
			exp_len <= '0;
			data_af <= 1'b0;
			len_af <= 1'b0;
		end else begin
			data_af <= (data_free <= 'd1);
			len_af <= (len_free <= 'd1);
			byte_wr <= 1'b0;
			len_wr <= 1'b0;

			// One pending byte per cycle, rest dropped past the frame end
			if (pend_cnt != 2'd0) begin
				if (room) begin
					byte_wr <= 1'b1;
					byte_cnt <= byte_cnt + 1'b1;
					pend_cnt <= pend_cnt - 2'd1;
				end else begin
					pend_cnt <= 2'd0;
				end
			end

			// Lowest byte goes out right after the transfer
			if (buf_wr && room) begin
				byte_wr <= 1'b1;
				byte_cnt <= byte_cnt + 1'b1;
				pend_cnt <= extra;
			end

			if (len_set)
				exp_len <= req.pwdata[`ETH_TX_LEN_WIDTH-1:0];

			// empty frames leave no length entry behind
			if (commit) begin
				len_wr <= (byte_cnt != '0);
				byte_cnt <= '0;
				exp_len <= '0;
			end
		end
	end

	// Payload path
	always_ff @(posedge apb) begin
		if (pend_cnt != 2'd0) begin
			byte_data <= pend_bytes[7:0];
			pend_bytes <= {8'd0, pend_bytes[23:8]};
		end
		if (buf_wr) begin
			byte_data <= req.pwdata[7:0];
			pend_bytes <= req.pwdata[31:8];
		end
		if (commit)
			len_data <= byte_cnt;
	end

	// Requester packs buffer bytes from byte 0 upward
	a_buf_strb: assert property (@(posedge apb) disable iff (rst)
		buf_wr |-> (req.pstrb inside {4'b0001, 4'b0011, 4'b0111, 4'b1111}));

endmodule

`default_nettype wire

/* verilog/eth_tx_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "eth_tx_macros.svh"

module eth_tx_buffer (
	input wire apb,
	input wire rst,
	input wire eth_tx_pkg::apb_req_t req,
	input wire link_up,
	input wire tx_ready,
	output eth_tx_pkg::apb_rsp_t rsp,
	output eth_tx_pkg::tx_bus_t tx
);

	////////////////////
	// Internal nets

	// Link down empties both FIFOs every cycle
	logic flush;

	// Register block to FIFOs
	logic byte_wr;
	logic [7:0] byte_wr_data;
	logic len_wr;
	eth_tx_pkg::frame_len_t len_wr_data;
	logic [$clog2(`ETH_TX_DATA_DEPTH + 1)-1:0] data_free;
	logic [$clog2(`ETH_TX_HDR_DEPTH + 1)-1:0] len_free;

	// FIFOs to sender
	logic byte_rd;
	logic [7:0] byte_rd_data;
	logic len_rd;
	eth_tx_pkg::frame_len_t len_rd_data;
	logic len_empty;

	assign flush = !link_up;

	////////////////////
	// Blocks

	apb_tx_regs i_apb_tx_regs (
		.apb(apb),
		.rst(rst),
		.req(req),
		.link_up(link_up),
		.data_free(data_free),
		.len_free(len_free),
		.rsp(rsp),
		.byte_wr(byte_wr),
		.byte_data(byte_wr_data),
		.len_wr(len_wr),
		.len_data(len_wr_data)
	);

	// Byte FIFO, emptiness follows the length FIFO
	sync_fifo #(
		.payload_t(logic [7:0]),
		.DEPTH(`ETH_TX_DATA_DEPTH)
	) i_data_fifo (
		.apb(apb),
		.rst(rst),
		.flush(flush),
		.wr(byte_wr),
		.wr_data(byte_wr_data),
		.rd(byte_rd),
		.rd_data(byte_rd_data),
		.empty(),
		.free_slots(data_free)
	);

	// One entry per committed frame
	sync_fifo #(
		.payload_t(eth_tx_pkg::frame_len_t),
		.DEPTH(`ETH_TX_HDR_DEPTH)
	) i_len_fifo (
		.apb(apb),
		.rst(rst),
		.flush(flush),
		.wr(len_wr),
		.wr_data(len_wr_data),
		.rd(len_rd),
		.rd_data(len_rd_data),
		.empty(len_empty),
		.free_slots(len_free)
	);

	tx_frame_sender i_tx_frame_sender (
		.apb(apb),
		.rst(rst),
		.link_up(link_up),
		.tx_ready(tx_ready),
		.len_empty(len_empty),
		.len_data(len_rd_data),
		.byte_data(byte_rd_data),
		.len_rd(len_rd),
		.byte_rd(byte_rd),
		.tx(tx)
	);

endmodule

`default_nettype wire

/* verilog/eth_tx_pkg.sv */
`default_nettype none

`include "eth_tx_macros.svh"

package eth_tx_pkg;

	////////////////////
	// APB

	// Request from the requester side
	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [`ETH_TX_ADDR_WIDTH-1:0] paddr;
		logic [31:0] pwdata;
		logic [3:0] pstrb;
	} apb_req_t;

	// Completer response
	// prdata and pslverr only mean something while pready is high
	typedef struct packed {
		logic pready;
		logic [31:0] prdata;
		logic pslverr;
	} apb_rsp_t;

	////////////////////
	// MAC side

	// Byte stream toward the MAC, start marks the first byte
	typedef struct packed {
		logic start;
		logic data_valid;
		logic [7:0] data;
	} tx_bus_t;

	// Frame byte count, payload of the length FIFO
	typedef logic [`ETH_TX_LEN_WIDTH-1:0] frame_len_t;

endpackage

`default_nettype wire

/* verilog/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 16
) (
	input wire apb,
	input wire rst,
	input wire flush,
	input wire wr,
	input wire payload_t wr_data,
	input wire rd,
	output payload_t rd_data,
	output logic empty,
	output logic [$clog2(DEPTH + 1)-1:0] free_slots
);

	// Pointers wrap on their own, DEPTH is a power of two
	localparam int ptr_width = $clog2(DEPTH);
	localparam int cnt_width = $clog2(DEPTH + 1);

	payload_t mem [DEPTH];

	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	// Entries held
	logic [cnt_width-1:0] count;

	////////////////////
	// Storage

	// Write stored at the edge, read data one cycle after the strobe
	always_ff @(posedge apb) begin
		if (wr)
			mem[wr_ptr] <= wr_data;
		if (rd)
			rd_data <= mem[rd_ptr];
	end

	////////////////////
	// Pointers

	always_ff @(posedge apb) begin
		// Flush drops everything held
		if (rst || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + cnt_width'(wr) - cnt_width'(rd);
		end
	end

	assign empty = (count == '0);
	// Upstream uses this for its almost-full stall
	assign free_slots = cnt_width'(DEPTH) - count;

	// Writer honours the free-slot count
	a_no_overflow: assert property (@(posedge apb) disable iff (rst || flush)
		wr |-> (free_slots != '0));

	// Reader only pops what is there
	a_no_underflow: assert property (@(posedge apb) disable iff (rst || flush)
		rd |-> !empty);

endmodule

`default_nettype wire

/* verilog/tx_frame_sender.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_frame_sender (
	input wire apb,
	input wire rst,
	input wire link_up,
	input wire tx_ready,
	input wire len_empty,
	input wire eth_tx_pkg::frame_len_t len_data,
	input wire [7:0] byte_data,
	output logic len_rd,
	output logic byte_rd,
	output eth_tx_pkg::tx_bus_t tx
);

	localparam int cnt_width = $bits(eth_tx_pkg::frame_len_t) + 1;

	typedef enum logic [1:0] {
		st_idle,
		st_pop,
		st_sending
	} state_t;

	state_t state;
	// Bytes popped in this frame
	eth_tx_pkg::frame_len_t rd_cnt;
	logic first_rd;
	logic start_q;
	logic valid_q;

	// Beats seen on the bus, for the length check
	logic [cnt_width-1:0] sent_cnt;
	logic [cnt_width-1:0] beat_num;

	// Data comes straight from the registered FIFO output
	assign tx = '{start: start_q, data_valid: valid_q, data: byte_data};

	always_ff @(posedge apb) begin
		// Link loss drops back to idle
		if (rst || !link_up) begin
			state <= st_idle;
			len_rd <= 1'b0;
			byte_rd <= 1'b0;
			first_rd <= 1'b0;
			start_q <= 1'b0;
			valid_q <= 1'b0;
			rd_cnt <= '0;
		end else begin
			len_rd <= 1'b0;
			byte_rd <= 1'b0;
			first_rd <= 1'b0;
			// Delay by the FIFO read latency
			start_q <= first_rd;
			valid_q <= byte_rd;
			case (state)
				// MAC ready only matters before a frame
				st_idle: begin
					if (!len_empty && tx_ready) begin
						len_rd <= 1'b1;
						state <= st_pop;
					end
				end
				st_pop: begin
					byte_rd <= 1'b1;
					first_rd <= 1'b1;
					rd_cnt <= 'd1;
					state <= st_sending;
				end
				// Length is valid from here on
				st_sending: begin
					if (rd_cnt >= len_data) begin
						state <= st_idle;
					end else begin
						byte_rd <= 1'b1;
						rd_cnt <= rd_cnt + 1'b1;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	assign beat_num = start_q ? cnt_width'(1) : sent_cnt + 1'b1;

	always_ff @(posedge apb) begin
		if (rst)
			sent_cnt <= '0;
		else if (valid_q)
			sent_cnt <= beat_num;
	end

	// Bus beats stay within the popped length
	a_frame_len: assert property (@(posedge apb) disable iff (rst || !link_up)
		valid_q |-> (beat_num <= {1'b0, len_data}));

endmodule

`default_nettype wire
